// ==== testbench/sl_trace.txt ====
# name packet(hex, 72 bit) ack_delay sym_count final_link_word(hex) chained
# chained 1: offered with pkt_vld held high while the packet before is in flight
short_zero        000000000000000000  2 11 60 0
short_high_junk   FF00000000000000C9  1 11 41 0
long_mixed        1000000000000000A2  2 19 72 0
long_backpressure FFFFFFFFFFFFFFFFFF 40 19 12 0
short_backpress   ABCDEF0000DEAD5678 25 11 55 0
b2b_short_a       000000000000000001  3 11 36 0
b2b_long_b        FFFFFFFFFFFFFFFFF3  3 19 47 1
b2b_short_c       000000000000000000  0 11 27 1

// ==== flist.f ====
+incdir+include
src/sl_pkg.sv
src/sl_pkt_serializer.sv
src/sl_symbol_transmitter.sv
src/spinnaker_link_tx.sv
testbench/sl_handshake_checker.sv
testbench/tb_spinnaker_link_tx.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spinnaker_link_tx
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_spinnaker_link_tx.sv ====
// ----------------------------------------------------------------------
// testbench for the link transmitter
//  clock, reset and trace reader
//  acknowledge model with random jitter, link monitor
//  symbol prediction, compare tasks and the closing report
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "sl_defines.svh"

module tb_spinnaker_link_tx;

  logic         CLK_IN, RESET_IN, pkt_vld, sl_ack;
  sl_pkg::pkt_t pkt_data;
  logic         pkt_rdy;
  sl_pkg::sym_t sl_data_2of7;

  string        names[$];
  sl_pkg::pkt_t pkts[$];
  int           delays[$], counts[$], chains[$];
  sl_pkg::sym_t finals[$];
  sl_pkg::sym_t obs_q[$];       // link changes seen, oldest first
  int           err_cnt = 0, fail_tests = 0, done_tests = 0;
  int           cur_delay = 0, cycles = 0, limit = 0;

  spinnaker_link_tx spinnaker_link_tx_i (
    .CLK_IN(CLK_IN), .RESET_IN(RESET_IN), .pkt_data(pkt_data), .pkt_vld(pkt_vld),
    .pkt_rdy(pkt_rdy), .sl_data_2of7(sl_data_2of7), .sl_ack(sl_ack)
  );

  initial begin
    CLK_IN = 1'b0;
    forever #50 CLK_IN = ~CLK_IN;  // 100 ns period
  end

  // two-hot wires per nibble, end-of-packet on the upper pair
  function automatic sl_pkg::sym_t nib_code(input logic [3:0] nib);
    logic [6:0] table_w [16] = '{7'h11, 7'h12, 7'h14, 7'h18, 7'h21, 7'h22, 7'h24, 7'h28,
                                 7'h41, 7'h42, 7'h44, 7'h48, 7'h03, 7'h06, 7'h0c, 7'h09};
    return table_w[nib];
  endfunction

  task automatic check_symbol(input string name, input sl_pkg::sym_t exp,
                              input sl_pkg::sym_t act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("ERROR %s: expected %0d actual %0d", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic read_trace();
    int fd, dly, cnt, chn;
    string line, nm;
    sl_pkg::pkt_t p;
    sl_pkg::sym_t fin;
    fd = $fopen("testbench/sl_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 2 && line[0] != "#" &&
          $sscanf(line, "%s %h %d %d %h %d", nm, p, dly, cnt, fin, chn) == 6) begin
        names.push_back(nm);
        pkts.push_back(p);
        delays.push_back(dly);
        counts.push_back(cnt);
        finals.push_back(fin);
        chains.push_back(chn);
        limit += 19 * (dly + 3 + 6);   // jitter bound is 3
      end
    end
    $fclose(fd);
  endtask

  // link monitor, sampled away from the rising edge
  initial begin
    sl_pkg::sym_t last;
    last = '0;
    forever begin
      @(negedge CLK_IN);
      if (!RESET_IN && sl_data_2of7 !== last) begin
        obs_q.push_back(sl_data_2of7);
        last = sl_data_2of7;
      end
    end
  end

  // acknowledge model, one toggle per link change
  initial begin
    sl_pkg::sym_t seen;
    int wait_c;
    seen = '0;
    forever begin
      @(negedge CLK_IN);
      if (!RESET_IN && sl_data_2of7 !== seen) begin
        seen   = sl_data_2of7;
        wait_c = cur_delay + ($urandom % 4);
        repeat (wait_c) @(negedge CLK_IN);
        sl_ack = ~sl_ack;
      end
    end
  end

  initial begin
    while (limit == 0 || cycles <= limit) begin
      @(posedge CLK_IN);
      cycles++;
    end
    $display("timeout after %0d cycles, the link stopped moving", cycles);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic drive_packets();
    for (int i = 0; i < names.size(); i++) begin
      if (!chains[i]) begin
        while (done_tests < i) @(negedge CLK_IN);
        @(negedge CLK_IN);
      end
      pkt_data = pkts[i];
      pkt_vld  = 1'b1;
      while (!pkt_rdy) @(negedge CLK_IN);
      @(negedge CLK_IN);                        // taken on the edge before
      if (pkt_rdy) begin
        $display("pkt_rdy stayed high after %s was taken", names[i]);
        err_cnt++;
      end
      if (i + 1 == names.size() || !chains[i + 1])
        pkt_vld = 1'b0;
    end
  endtask

  task automatic check_packets();
    sl_pkg::pkt_t p;
    sl_pkg::sym_t word, act, prev;
    int nn, extra, e0, eop_at;
    word = '0;
    prev = '0;
    for (int i = 0; i < names.size(); i++) begin
      cur_delay = delays[i];
      e0        = err_cnt;
      p         = pkts[i];
      nn        = p[1] ? `SL_LONG_NIBS : `SL_SHORT_NIBS;
      eop_at    = 0;
      for (int k = 0; k <= nn; k++) begin
        word = word ^ ((k < nn) ? nib_code(p[4*k +: 4]) : 7'b1100000);
        while (obs_q.size() == 0) @(negedge CLK_IN);
        act = obs_q.pop_front();
        check_symbol($sformatf("%s symbol %0d", names[i], k), word, act);
        if (eop_at == 0 && (act ^ prev) == 7'b1100000)
          eop_at = k + 1;                       // end symbol seen on the link
        prev = act;
      end
      check_symbol({names[i], " final word"}, finals[i], act);
      extra = 0;
      if (i + 1 == names.size() || !chains[i + 1]) begin
        while (!pkt_rdy) @(negedge CLK_IN);
        repeat (cur_delay + 16) @(negedge CLK_IN);  // nothing more may follow
        extra = obs_q.size();
        obs_q.delete();
      end
      check_count({names[i], " symbol count"}, counts[i], eop_at + extra);
      if (err_cnt != e0)
        fail_tests++;
      $display("test %s: %s, %0d symbols", names[i], (err_cnt == e0) ? "ok" : "failed",
               eop_at + extra);
      done_tests++;
    end
  endtask

  initial begin
    void'($urandom(56));
    RESET_IN = 1'b1;
    pkt_vld  = 1'b0;
    pkt_data = '0;
    sl_ack   = 1'b0;
    read_trace();
    limit += 200 + 16;
    repeat (16) @(posedge CLK_IN);
    @(negedge CLK_IN) RESET_IN = 1'b0;
    check_symbol("reset link word", '0, sl_data_2of7);
    repeat (2) @(negedge CLK_IN);
    if (!pkt_rdy) begin
      $display("pkt_rdy did not rise after reset");
      err_cnt++;
    end
    if (names.size() == 0) begin
      $display("the trace holds no tests");
      err_cnt++;
    end
    fork
      drive_packets();
      check_packets();
    join
    err_cnt += spinnaker_link_tx_i.sl_handshake_checker_i.ack_fails;
    err_cnt += spinnaker_link_tx_i.sl_handshake_checker_i.code_fails;
    $display("tests %0d, failed %0d, errors %0d", names.size(), fail_tests, err_cnt);
    if (err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/sl_handshake_checker.sv ====
// ----------------------------------------------------------------------
// link handshake assertions, bound to the transmitter top level
//  one acknowledge toggle between two link changes
//  every link change toggles exactly two wires
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sl_handshake_checker (
  input wire               CLK_IN,
  input wire               RESET_IN,
  input wire sl_pkg::sym_t sl_data_2of7,
  input wire               sl_ack
);

  sl_pkg::sym_t data_q;         // link word one cycle back
  logic         ack_q;
  logic         tog_seen;       // ack toggled since last link change
  logic         data_chg;
  int           ack_fails  = 0; // read by the testbench
  int           code_fails = 0;

  assign data_chg = (sl_data_2of7 != data_q);

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      data_q   <= '0;
      ack_q    <= 1'b0;
      tog_seen <= 1'b1;         // first symbol goes out unacknowledged
    end else begin
      data_q <= sl_data_2of7;
      ack_q  <= sl_ack;
      if (data_chg)
        tog_seen <= (sl_ack != ack_q);
      else if (sl_ack != ack_q)
        tog_seen <= 1'b1;
    end
  end

  ack_between: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    data_chg |-> tog_seen)
    else begin
      $error("link word changed twice without an acknowledge toggle");
      ack_fails++;
    end

  two_wires: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    data_chg |-> ($countones(sl_data_2of7 ^ data_q) == 2))
    else begin
      $error("link change did not toggle exactly two wires");
      code_fails++;
    end

endmodule

bind spinnaker_link_tx sl_handshake_checker sl_handshake_checker_i (
  .CLK_IN       (CLK_IN),
  .RESET_IN     (RESET_IN),
  .sl_data_2of7 (sl_data_2of7),
  .sl_ack       (sl_ack)
);

`default_nettype wire

// ==== src/spinnaker_link_tx.sv ====
// ----------------------------------------------------------------------
// link transmitter top level
//  packet serializer feeding the symbol transmitter
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spinnaker_link_tx (
  input  wire               CLK_IN,
  input  wire               RESET_IN,
  // packet side
  input  wire sl_pkg::pkt_t pkt_data,
  input  wire               pkt_vld,
  output logic              pkt_rdy,
  // link side
  output sl_pkg::sym_t      sl_data_2of7,
  input  wire               sl_ack
);

  // flit channel
  sl_pkg::sym_t flt_data;  // next NRZ word
  logic         flt_vld;
  logic         flt_rdy;

  sl_pkt_serializer sl_pkt_serializer_i (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_data (flt_data),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy)
  );

  sl_symbol_transmitter sl_symbol_transmitter_i (
    .CLK_IN       (CLK_IN),
    .RESET_IN     (RESET_IN),
    .flt_data     (flt_data),
    .flt_vld      (flt_vld),
    .flt_rdy      (flt_rdy),
    .sl_data_2of7 (sl_data_2of7),
    .sl_ack       (sl_ack)      // raw, synchronized inside
  );

endmodule

`default_nettype wire

// ==== src/sl_symbol_transmitter.sv ====
// ----------------------------------------------------------------------
// link symbol transmitter
//  two-flop acknowledge synchronizer and toggle detect
//  pending acknowledge flag and inter-symbol delay counter
//  link output register
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "sl_defines.svh"

module sl_symbol_transmitter (
  input  wire               CLK_IN,
  input  wire               RESET_IN,
  // flit channel from the serializer
  input  wire sl_pkg::sym_t flt_data,
  input  wire               flt_vld,
  output logic              flt_rdy,
  // link side
  output sl_pkg::sym_t      sl_data_2of7,
  input  wire               sl_ack
);

  localparam int DLY_W = (`SL_INTER_SYM_DELAY > 1) ? $clog2(`SL_INTER_SYM_DELAY + 1) : 1;

  logic             ack_s1;    // first sync stage
  logic             ack_s2;    // synchronized acknowledge
  logic             ack_old;   // previous synchronized value
  logic             ack_tog;   // acknowledge transition seen
  logic             ack_pend;  // symbol sent, no acknowledge yet
  logic             send;      // symbol moves this cycle
  logic [DLY_W-1:0] dly_cnt;   // cycles left before next send

  // ----------------------------------------------------------------------
  // acknowledge
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_s1  <= 1'b0;
      ack_s2  <= 1'b0;
      ack_old <= 1'b0;
    end else begin
      ack_s1  <= sl_ack;
      ack_s2  <= ack_s1;
      ack_old <= ack_s2;
    end
  end

  assign ack_tog = ack_s2 ^ ack_old;  // NRZ ack, either edge counts

  // link starts out acknowledged
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      ack_pend <= 1'b0;
    else if (send)
      ack_pend <= 1'b1;
    else if (ack_tog)
      ack_pend <= 1'b0;
  end

  // ----------------------------------------------------------------------
  // inter-symbol delay
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      dly_cnt <= '0;
    else if (send)
      dly_cnt <= DLY_W'(`SL_INTER_SYM_DELAY);
    else if (dly_cnt != '0)
      dly_cnt <= dly_cnt - 1'b1;
  end

  // ----------------------------------------------------------------------
  // flit handshake and link output
  // ----------------------------------------------------------------------
  assign flt_rdy = !ack_pend && (dly_cnt == '0);
  assign send    = flt_vld && flt_rdy;

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      sl_data_2of7 <= '0;
    else if (send)
      sl_data_2of7 <= flt_data;  // word already carries the toggle
  end

endmodule

`default_nettype wire

// ==== src/sl_pkt_serializer.sv ====
// ----------------------------------------------------------------------
// packet serializer
//  packet shift buffer and length flag
//  nibble counter with end-of-packet detect
//  IDLE / PARK / TRAN state machine
//  NRZ 2-of-7 word register on the flit channel
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "sl_defines.svh"

module sl_pkt_serializer (
  input  wire               CLK_IN,
  input  wire               RESET_IN,
  // packet side
  input  wire sl_pkg::pkt_t pkt_data,
  input  wire               pkt_vld,
  output logic              pkt_rdy,
  // flit channel towards the transmitter
  output sl_pkg::sym_t      flt_data,
  output logic              flt_vld,
  input  wire               flt_rdy
);

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  sl_pkg::ser_state_e       state;
  sl_pkg::pkt_t             pkt_buf;   // remaining nibbles, low first
  logic                     pkt_long;  // length bit of current packet
  logic                     pkt_acpt;  // packet taken this cycle
  logic                     flt_busy;  // word waiting, transmitter not ready
  logic [4:0]               nib_cnt;   // words loaded in this packet
  logic                     eop;       // next word is end-of-packet
  logic [`SL_NIB_BITS-1:0]  fnib;      // nibble fed to the encoder

  assign pkt_acpt = pkt_vld && pkt_rdy;
  assign flt_busy = flt_vld && !flt_rdy;

  assign eop = (!pkt_long && (nib_cnt == 5'(`SL_SHORT_NIBS))) ||
               (nib_cnt == 5'(`SL_LONG_NIBS));

  assign fnib = (state == sl_pkg::IDLE) ? pkt_data[`SL_NIB_BITS-1:0]
                                        : pkt_buf[`SL_NIB_BITS-1:0];

  // ----------------------------------------------------------------------
  // packet side
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_rdy <= 1'b0;
    end else begin
      case (state)
        sl_pkg::IDLE: pkt_rdy <= !pkt_acpt;          // drop once a packet is in
        sl_pkg::PARK: pkt_rdy <= 1'b0;
        default:      pkt_rdy <= eop && !flt_busy;   // end word just loaded
      endcase
    end
  end

  always_ff @(posedge CLK_IN) begin
    case (state)
      sl_pkg::IDLE: begin
        if (pkt_acpt) begin
          if (flt_busy)
            pkt_buf <= pkt_data;                     // park whole packet
          else
            pkt_buf <= pkt_data >> `SL_NIB_BITS;     // first nibble goes now
        end
      end
      default: begin
        if (!flt_busy)
          pkt_buf <= pkt_buf >> `SL_NIB_BITS;        // next nibble to the bottom
      end
    endcase
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      pkt_long <= 1'b0;
    else if ((state == sl_pkg::IDLE) && pkt_acpt)
      pkt_long <= pkt_data[1];
  end

  // ----------------------------------------------------------------------
  // flit channel
  // ----------------------------------------------------------------------
  // NRZ word, each symbol toggles its two wires
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      flt_data <= '0;
    else if (!flt_busy && (pkt_acpt || (state != sl_pkg::IDLE)))
      flt_data <= flt_data ^ sl_pkg::code_2of7(fnib, eop);
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      flt_vld <= 1'b0;
    else if (state != sl_pkg::IDLE)
      flt_vld <= 1'b1;                 // a word is always ready mid packet
    else if (!flt_busy)
      flt_vld <= pkt_acpt;             // first word, or nothing left
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN)
      nib_cnt <= '0;
    else if (state != sl_pkg::TRAN)
      nib_cnt <= 5'd1;                 // first word loads on leaving
    else if (!flt_busy)
      nib_cnt <= nib_cnt + 5'd1;
  end

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= sl_pkg::IDLE;
    end else begin
      case (state)
        sl_pkg::IDLE: begin
          if (pkt_acpt)
            state <= flt_busy ? sl_pkg::PARK : sl_pkg::TRAN;
        end
        sl_pkg::PARK: begin
          if (!flt_busy)
            state <= sl_pkg::TRAN;     // end word gone, start parked packet
        end
        default: begin
          if (eop && !flt_busy)
            state <= sl_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/sl_pkg.sv ====
// ----------------------------------------------------------------------
// shared types for the link transmitter
//  packet and link word types, serializer states
//  2-of-7 code table for data nibbles and end-of-packet
// ----------------------------------------------------------------------
`default_nettype none
`include "sl_defines.svh"

package sl_pkg;

  typedef logic [`SL_PKT_BITS-1:0] pkt_t;  // bit 1 set means long packet
  typedef logic [`SL_SYM_BITS-1:0] sym_t;  // one bit per link wire

  // serializer FSM
  typedef enum logic [1:0] {
    IDLE,  // waiting for a packet
    PARK,  // packet held while the end symbol still waits
    TRAN   // sending nibbles
  } ser_state_e;

  // two-hot code of a symbol, the link word is toggled by it
  function automatic sym_t code_2of7(input logic [`SL_NIB_BITS-1:0] nib,
                                     input logic                    eop);
    sym_t code;
    if (eop) begin
      code = 7'b1100000;  // end-of-packet uses the two upper wires
    end else begin
      case (nib)
        4'h0:    code = 7'b0010001;
        4'h1:    code = 7'b0010010;
        4'h2:    code = 7'b0010100;
        4'h3:    code = 7'b0011000;
        4'h4:    code = 7'b0100001;
        4'h5:    code = 7'b0100010;
        4'h6:    code = 7'b0100100;
        4'h7:    code = 7'b0101000;
        4'h8:    code = 7'b1000001;
        4'h9:    code = 7'b1000010;
        4'ha:    code = 7'b1000100;
        4'hb:    code = 7'b1001000;
        4'hc:    code = 7'b0000011;
        4'hd:    code = 7'b0000110;
        4'he:    code = 7'b0001100;
        default: code = 7'b0001001;  // nibble 15
      endcase
    end
    return code;
  endfunction

endpackage

`default_nettype wire

// ==== include/sl_defines.svh ====
// ----------------------------------------------------------------------
// build-time constants for the link transmitter
//  packet, nibble and link symbol widths
//  nibble counts of short and long packets
//  idle cycles kept between two sent symbols
// ----------------------------------------------------------------------
`ifndef SL_DEFINES_SVH
`define SL_DEFINES_SVH

`define SL_PKT_BITS        72   // full long packet
`define SL_NIB_BITS        4    // one data nibble per symbol
`define SL_SYM_BITS        7    // 2-of-7 link wires

// nibbles per packet, end-of-packet symbol not included
`define SL_SHORT_NIBS      10
`define SL_LONG_NIBS       18

// clock cycles between consecutive symbols on the link
`define SL_INTER_SYM_DELAY 1

`endif
